// ==== rtl/calc_config.svh ====
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

`define DIGIT_W        4
`define ENTRY_DIGITS   3
`define VALUE_W        16
`define BCD_DIGITS     5
`define SWITCH_W       15
`define BUTTON_W       5

// Button bit positions, lowest index has priority
`define BTN_UP         0
`define BTN_DOWN       1
`define BTN_LEFT       2
`define BTN_RIGHT      3
`define BTN_MID        4

`define CONVERT_CYCLES 16
`define PAGE_LIMIT     999

`endif

// ==== rtl/calc_ctrl_pkg.sv ====
`default_nettype none

package calc_ctrl_pkg;

    // Calculator phase, one entry per top-level step
    typedef enum logic [2:0] {
        PH_ENTRY_A = 3'd0,
        PH_ENTRY_B = 3'd1,
        PH_EXECUTE = 3'd2,
        PH_CONVERT = 3'd3,
        PH_DISPLAY = 3'd4
    } phase_t;

    // Operation picked from the switches
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_MUL  = 3'd2,
        OP_DIV  = 3'd3,
        OP_NONE = 3'd4
    } op_t;

endpackage

`default_nettype wire

// ==== rtl/calc_num_pkg.sv ====
`default_nettype none

`include "calc_config.svh"

package calc_num_pkg;

    typedef logic [`DIGIT_W-1:0] bcd_t;

    // Digit 0 is the least significant
    typedef struct packed {
        logic                        sign;
        bcd_t [`ENTRY_DIGITS-1:0]    digit;
    } entry_t;

    typedef logic signed [`VALUE_W-1:0] value_t;

    // Decimal digits sit above the binary part that is shifted into them
    typedef struct packed {
        bcd_t [`BCD_DIGITS-1:0]      digit;
        logic [`VALUE_W-1:0]         bin;
    } conv_fields_t;

    typedef union packed {
        logic [`BCD_DIGITS*`DIGIT_W+`VALUE_W-1:0] raw;
        conv_fields_t                             fields;
    } conv_word_u;

endpackage

`default_nettype wire

// ==== rtl/calc_flow_if.sv ====
`default_nettype none

interface calc_flow_if;

    calc_ctrl_pkg::phase_t phase;

    // Decoded buttons, at most one high per cycle
    logic btn_up;
    logic btn_down;
    logic btn_left;
    logic btn_right;
    logic btn_mid;

    logic capture_a;
    logic capture_b;

    modport ctrl (
        output phase, btn_up, btn_down, btn_left, btn_right, btn_mid, capture_a, capture_b
    );

    modport unit (
        input phase, btn_up, btn_down, btn_left, btn_right, btn_mid, capture_a, capture_b
    );

endinterface

`default_nettype wire

// ==== rtl/calc_control.sv ====
`default_nettype none

`include "calc_config.svh"

module calc_control (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [`BUTTON_W-1:0]  buttons,
    input  wire [`SWITCH_W-1:0]  switches,
    input  wire                  convert_done,
    input  wire                  last_page,
    calc_flow_if.ctrl            flow,
    output calc_ctrl_pkg::op_t   op
);

    logic [`BUTTON_W-1:0]   btn_qual;
    calc_ctrl_pkg::phase_t  phase_q;
    calc_ctrl_pkg::phase_t  phase_d;
    logic [3:0]             sw_q;

    // Keep only the lowest set button
    assign btn_qual = buttons & (~buttons + 1'b1);

    assign flow.btn_up    = btn_qual[`BTN_UP];
    assign flow.btn_down  = btn_qual[`BTN_DOWN];
    assign flow.btn_left  = btn_qual[`BTN_LEFT];
    assign flow.btn_right = btn_qual[`BTN_RIGHT];
    assign flow.btn_mid   = btn_qual[`BTN_MID];

    assign flow.phase     = phase_q;
    assign flow.capture_a = (phase_q == calc_ctrl_pkg::PH_ENTRY_A) && flow.btn_mid;
    assign flow.capture_b = (phase_q == calc_ctrl_pkg::PH_ENTRY_B) && flow.btn_mid;

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            calc_ctrl_pkg::PH_ENTRY_A: if (flow.btn_mid) phase_d = calc_ctrl_pkg::PH_ENTRY_B;
            calc_ctrl_pkg::PH_ENTRY_B: if (flow.btn_mid) phase_d = calc_ctrl_pkg::PH_EXECUTE;
            calc_ctrl_pkg::PH_EXECUTE: phase_d = calc_ctrl_pkg::PH_CONVERT;
            calc_ctrl_pkg::PH_CONVERT: if (convert_done) phase_d = calc_ctrl_pkg::PH_DISPLAY;
            calc_ctrl_pkg::PH_DISPLAY: begin
                if (flow.btn_mid && last_page) phase_d = calc_ctrl_pkg::PH_ENTRY_A;
            end
            default: phase_d = calc_ctrl_pkg::PH_ENTRY_A;
        endcase
    end

    // Switches 4 and up select nothing supported
    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= calc_ctrl_pkg::PH_ENTRY_A;
            sw_q    <= '0;
        end else begin
            phase_q <= phase_d;
            if (flow.capture_b) sw_q <= switches[3:0];
        end
    end

    always_comb begin
        if (sw_q[0]) begin
            op = calc_ctrl_pkg::OP_ADD;
        end else if (sw_q[1]) begin
            op = calc_ctrl_pkg::OP_SUB;
        end else if (sw_q[2]) begin
            op = calc_ctrl_pkg::OP_MUL;
        end else if (sw_q[3]) begin
            op = calc_ctrl_pkg::OP_DIV;
        end else begin
            op = calc_ctrl_pkg::OP_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/operand_entry.sv ====
`default_nettype none

`include "calc_config.svh"

module operand_entry (
    input  wire                    clk,
    input  wire                    rst,
    calc_flow_if.unit              flow,
    output calc_num_pkg::entry_t   live_entry,
    output calc_num_pkg::value_t   opnd_a,
    output calc_num_pkg::value_t   opnd_b
);

    // Slots 0 to ENTRY_DIGITS-1 are digits, the last one is the sign
    localparam int SLOT_SIGN = `ENTRY_DIGITS;

    logic [$clog2(`ENTRY_DIGITS + 1)-1:0] cursor;
    logic                                 in_entry;
    logic                                 capture;
    calc_num_pkg::bcd_t                   cur_digit;
    calc_num_pkg::bcd_t                   step_digit;
    logic [`VALUE_W-1:0]                  entry_mag;
    calc_num_pkg::value_t                 entry_val;

    assign in_entry = (flow.phase == calc_ctrl_pkg::PH_ENTRY_A) ||
                      (flow.phase == calc_ctrl_pkg::PH_ENTRY_B);
    assign capture  = flow.capture_a || flow.capture_b;

    always_comb begin
        cur_digit = live_entry.digit[0];
        for (int i = 1; i < `ENTRY_DIGITS; i++) begin
            if (cursor == i) cur_digit = live_entry.digit[i];
        end
    end

    // Wraps modulo 10
    always_comb begin
        if (flow.btn_up) begin
            step_digit = (cur_digit == 4'd9) ? 4'd0 : cur_digit + 4'd1;
        end else begin
            step_digit = (cur_digit == 4'd0) ? 4'd9 : cur_digit - 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || capture) begin
            cursor     <= '0;
            live_entry <= '0;
        end else if (in_entry) begin
            if (flow.btn_left && cursor != SLOT_SIGN) cursor <= cursor + 1'b1;
            if (flow.btn_right && cursor != 0) cursor <= cursor - 1'b1;
            if (flow.btn_up || flow.btn_down) begin
                if (cursor == SLOT_SIGN) live_entry.sign <= ~live_entry.sign;
                for (int i = 0; i < `ENTRY_DIGITS; i++) begin
                    if (cursor == i) live_entry.digit[i] <= step_digit;
                end
            end
        end
    end

    assign entry_mag = `VALUE_W'(live_entry.digit[0])
                     + `VALUE_W'(live_entry.digit[1]) * `VALUE_W'd10
                     + `VALUE_W'(live_entry.digit[2]) * `VALUE_W'd100;

    assign entry_val = live_entry.sign ? -entry_mag : entry_mag;

    // Held until the next capture of the same operand
    always_ff @(posedge clk) begin
        if (flow.capture_a) opnd_a <= entry_val;
        if (flow.capture_b) opnd_b <= entry_val;
    end

endmodule

`default_nettype wire

// ==== rtl/result_unit.sv ====
`default_nettype none

`include "calc_config.svh"

module result_unit (
    input  wire                        clk,
    input  wire                        rst,
    calc_flow_if.unit                  flow,
    input  wire calc_ctrl_pkg::op_t    op,
    input  wire calc_num_pkg::value_t  opnd_a,
    input  wire calc_num_pkg::value_t  opnd_b,
    output logic                       convert_done,
    output logic                       last_page,
    output logic                       page,
    output calc_num_pkg::conv_word_u   result_word,
    output logic                       result_neg,
    output logic                       invalid
);

    localparam int CONV_W = $bits(calc_num_pkg::conv_word_u);
    localparam int CNT_W  = $clog2(`CONVERT_CYCLES);

    typedef logic signed [2*`VALUE_W-1:0] wide_t;

    wide_t                     wide;
    logic                      div_zero;
    logic                      out_of_range;
    logic                      invalid_d;
    logic                      in_execute;
    logic                      in_convert;
    logic                      in_display;
    calc_num_pkg::value_t      result_q;
    logic [`VALUE_W-1:0]       res_mag;
    logic [CNT_W-1:0]          cvt_cnt;
    calc_num_pkg::conv_word_u  conv_q;
    calc_num_pkg::conv_word_u  conv_adj;

    assign in_execute = flow.phase == calc_ctrl_pkg::PH_EXECUTE;
    assign in_convert = flow.phase == calc_ctrl_pkg::PH_CONVERT;
    assign in_display = flow.phase == calc_ctrl_pkg::PH_DISPLAY;

    always_comb begin
        wide     = '0;
        div_zero = 1'b0;
        case (op)
            calc_ctrl_pkg::OP_ADD: wide = wide_t'(opnd_a) + wide_t'(opnd_b);
            calc_ctrl_pkg::OP_SUB: wide = wide_t'(opnd_a) - wide_t'(opnd_b);
            calc_ctrl_pkg::OP_MUL: wide = wide_t'(opnd_a) * wide_t'(opnd_b);
            calc_ctrl_pkg::OP_DIV: begin
                if (opnd_b == '0) begin
                    div_zero = 1'b1;
                end else begin
                    wide = wide_t'(opnd_a / opnd_b);
                end
            end
            default: wide = '0;
        endcase
    end

    // Upper half plus the 16-bit sign must all agree
    assign out_of_range = (wide[2*`VALUE_W-1:`VALUE_W-1] != '0) &&
                          (wide[2*`VALUE_W-1:`VALUE_W-1] != '1);
    assign invalid_d    = div_zero || out_of_range || (op == calc_ctrl_pkg::OP_NONE);

    always_ff @(posedge clk) begin
        if (in_execute) result_q <= wide[`VALUE_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            invalid <= 1'b0;
        end else if (in_execute) begin
            invalid <= invalid_d;
        end
    end

    assign result_neg = result_q[`VALUE_W-1];
    assign res_mag    = result_neg ? $unsigned(-result_q) : $unsigned(result_q);

    // Add 3 to every digit of 5 or more before the next shift
    always_comb begin
        conv_adj = conv_q;
        for (int i = 0; i < `BCD_DIGITS; i++) begin
            if (conv_q.fields.digit[i] > 4'd4) begin
                conv_adj.fields.digit[i] = conv_q.fields.digit[i] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || in_execute) begin
            cvt_cnt <= '0;
        end else if (in_convert) begin
            cvt_cnt <= cvt_cnt + 1'b1;
        end
    end

    // First cycle loads with the first shift already done
    always_ff @(posedge clk) begin
        if (in_convert) begin
            if (cvt_cnt == '0) begin
                conv_q.raw <= CONV_W'(res_mag) << 1;
            end else begin
                conv_q.raw <= conv_adj.raw << 1;
            end
        end
    end

    assign convert_done = in_convert && (cvt_cnt == CNT_W'(`CONVERT_CYCLES - 1));
    assign result_word  = conv_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            page <= 1'b0;
        end else if (convert_done) begin
            page <= !invalid && (res_mag > `PAGE_LIMIT);
        end else if (in_display && flow.btn_mid) begin
            page <= 1'b0;
        end
    end

    assign last_page = !page;

endmodule

`default_nettype wire

// ==== rtl/display_scan.sv ====
`default_nettype none

`include "calc_config.svh"

module display_scan (
    input  wire                            clk,
    input  wire                            rst,
    calc_flow_if.unit                      flow,
    input  wire calc_num_pkg::entry_t      live_entry,
    input  wire calc_num_pkg::conv_word_u  result_word,
    input  wire                            result_neg,
    input  wire                            invalid,
    input  wire                            page,
    output logic [3:0]                     digit_ctrl,
    output logic [7:0]                     digit_seg
);

    // Codes above 9 for non-numeric slots
    localparam calc_num_pkg::bcd_t CODE_MINUS = 4'hA;
    localparam calc_num_pkg::bcd_t CODE_BLANK = 4'hF;

    logic [1:0]          slot_q;
    logic [1:0]          slot_d;
    logic                show_q;
    logic                active;
    logic                in_entry;
    calc_num_pkg::bcd_t  code;

    function automatic logic [7:0] seg_pattern(input calc_num_pkg::bcd_t c);
        case (c)
            4'd0:       return 8'b1111_1100;
            4'd1:       return 8'b0110_0000;
            4'd2:       return 8'b1101_1010;
            4'd3:       return 8'b1111_0010;
            4'd4:       return 8'b0110_0110;
            4'd5:       return 8'b1011_0110;
            4'd6:       return 8'b1011_1110;
            4'd7:       return 8'b1110_0000;
            4'd8:       return 8'b1111_1110;
            4'd9:       return 8'b1110_0110;
            CODE_MINUS: return 8'b0000_0010;
            default:    return 8'b0000_0000;
        endcase
    endfunction

    assign in_entry = (flow.phase == calc_ctrl_pkg::PH_ENTRY_A) ||
                      (flow.phase == calc_ctrl_pkg::PH_ENTRY_B);
    assign active   = in_entry || ((flow.phase == calc_ctrl_pkg::PH_DISPLAY) && !invalid);
    assign slot_d   = active ? slot_q + 2'd1 : slot_q;

    // Pick what the next slot shows
    always_comb begin
        code = CODE_BLANK;
        if (in_entry) begin
            if (slot_d == 2'd3) code = live_entry.sign ? CODE_MINUS : CODE_BLANK;
            else code = live_entry.digit[slot_d];
        end else if (page) begin
            if (!slot_d[1]) begin
                code = slot_d[0] ? result_word.fields.digit[4] : result_word.fields.digit[3];
            end
        end else begin
            if (slot_d == 2'd3) code = result_neg ? CODE_MINUS : CODE_BLANK;
            else code = result_word.fields.digit[slot_d];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_q    <= 2'd0;
            show_q    <= 1'b0;
            digit_seg <= 8'b0;
        end else begin
            slot_q    <= slot_d;
            show_q    <= active;
            digit_seg <= seg_pattern(code);
        end
    end

    // Active low select
    assign digit_ctrl = show_q ? ~(4'b0001 << slot_q) : 4'b1111;

endmodule

`default_nettype wire

// ==== rtl/calc_top.sv ====
`default_nettype none

`include "calc_config.svh"

module calc_top (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [`BUTTON_W-1:0]  board_button,
    input  wire [`SWITCH_W-1:0]  board_switches,
    output logic [3:0]           digit_ctrl,
    output logic [7:0]           digit_seg,
    output logic                 exe_done,
    output logic [2:0]           display_stage
);

    calc_ctrl_pkg::op_t        op;
    calc_num_pkg::entry_t      live_entry;
    calc_num_pkg::value_t      opnd_a;
    calc_num_pkg::value_t      opnd_b;
    calc_num_pkg::conv_word_u  result_word;
    logic                      convert_done;
    logic                      last_page;
    logic                      page;
    logic                      result_neg;
    logic                      invalid;

    calc_flow_if flow ();

    calc_control u_control (
        .clk          (clk),
        .rst          (rst),
        .buttons      (board_button),
        .switches     (board_switches),
        .convert_done (convert_done),
        .last_page    (last_page),
        .flow         (flow.ctrl),
        .op           (op)
    );

    operand_entry u_entry (
        .clk        (clk),
        .rst        (rst),
        .flow       (flow.unit),
        .live_entry (live_entry),
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b)
    );

    result_unit u_result (
        .clk          (clk),
        .rst          (rst),
        .flow         (flow.unit),
        .op           (op),
        .opnd_a       (opnd_a),
        .opnd_b       (opnd_b),
        .convert_done (convert_done),
        .last_page    (last_page),
        .page         (page),
        .result_word  (result_word),
        .result_neg   (result_neg),
        .invalid      (invalid)
    );

    display_scan u_display (
        .clk         (clk),
        .rst         (rst),
        .flow        (flow.unit),
        .live_entry  (live_entry),
        .result_word (result_word),
        .result_neg  (result_neg),
        .invalid     (invalid),
        .page        (page),
        .digit_ctrl  (digit_ctrl),
        .digit_seg   (digit_seg)
    );

    assign exe_done      = flow.phase == calc_ctrl_pkg::PH_DISPLAY;
    assign display_stage = {2'b00, page};

endmodule

`default_nettype wire

// ==== testbench/calc_asserts.sv ====
`default_nettype none

module calc_asserts (
    input wire       clk,
    input wire       rst,
    input wire [3:0] digit_ctrl,
    input wire       exe_done,
    input wire [2:0] display_stage
);

    logic ctrl_legal;

    // One digit selected, or all digits off
    assign ctrl_legal = (digit_ctrl == 4'b1110) || (digit_ctrl == 4'b1101) ||
                        (digit_ctrl == 4'b1011) || (digit_ctrl == 4'b0111) ||
                        (digit_ctrl == 4'b1111);

    ctrl_one_hot: assert property (@(posedge clk) disable iff (rst) ctrl_legal)
        else $error("digit_ctrl %h is not a legal digit select", digit_ctrl);

    stage_range: assert property (@(posedge clk) disable iff (rst) display_stage <= 3'd1)
        else $error("display_stage %h is above 1", display_stage);

    // Page only moves while the result is shown
    stage_steady: assert property (@(posedge clk) disable iff (rst)
        !$stable(display_stage) |-> exe_done)
        else $error("display_stage changed while exe_done was low");

    stage_idle: assert property (@(posedge clk) disable iff (rst)
        !exe_done |-> display_stage == 3'd0)
        else $error("display_stage %h is not zero outside the display phase", display_stage);

    reset_state: assert property (@(posedge clk) rst |=> !exe_done && display_stage == 3'd0)
        else $error("exe_done or display_stage not cleared by reset");

endmodule

bind calc_top calc_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .digit_ctrl    (digit_ctrl),
    .exe_done      (exe_done),
    .display_stage (display_stage)
);

`default_nettype wire

// ==== testbench/calc_tb.sv ====
`default_nettype none

`include "calc_config.svh"

module calc_tb;

    localparam int N_TESTS     = 16;
    localparam int TEST_CYCLES = 200;
    localparam int M_ENTRY     = 0;
    localparam int M_BUSY      = 1;
    localparam int M_DISPLAY   = 2;
    localparam logic [7:0] MINUS_SEG = 8'h02;
    localparam logic [7:0] DIGIT_SEGS [10] = '{
        8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0, 8'hFE, 8'hE6
    };

    logic                 clk;
    logic                 rst;
    logic [`BUTTON_W-1:0] board_button;
    logic [`SWITCH_W-1:0] board_switches;
    wire  [3:0]           digit_ctrl;
    wire  [7:0]           digit_seg;
    wire                  exe_done;
    wire  [2:0]           display_stage;

    integer seed;

    // Expected values seen by the assertions
    logic       check_en;
    logic [7:0] exp_seg [4];
    logic [7:0] exp_now;
    logic       exp_blank;
    logic       exp_done;
    logic [2:0] exp_stage;

    // Reference model
    int         m_dig [3];
    logic       m_sign;
    int         m_cursor;
    int         m_mode;
    logic       m_in_b;
    int         m_a;
    int         m_b;
    logic [3:0] m_sw;
    int         res_dig [5];
    logic       res_neg;
    logic       res_valid;
    logic       res_page;

    calc_top uut (
        .clk            (clk),
        .rst            (rst),
        .board_button   (board_button),
        .board_switches (board_switches),
        .digit_ctrl     (digit_ctrl),
        .digit_seg      (digit_seg),
        .exe_done       (exe_done),
        .display_stage  (display_stage)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic value_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] want);
        stop_with_failure($sformatf("Fail %s: got %h, expected %h", name, got, want));
    endtask

    always_comb begin
        case (digit_ctrl)
            4'b1110: exp_now = exp_seg[0];
            4'b1101: exp_now = exp_seg[1];
            4'b1011: exp_now = exp_seg[2];
            default: exp_now = exp_seg[3];
        endcase
    end

    seg_check: assert property (@(posedge clk) disable iff (rst || !check_en)
        (digit_ctrl != 4'hF) |-> (digit_seg == exp_now))
        else value_mismatch("digit_seg", $sampled(digit_seg), $sampled(exp_now));

    blank_check: assert property (@(posedge clk) disable iff (rst || !check_en)
        exp_blank |-> (digit_ctrl == 4'hF))
        else value_mismatch("digit_ctrl", $sampled(digit_ctrl), 16'hF);

    scan_check: assert property (@(posedge clk) disable iff (rst || !check_en)
        !exp_blank |-> (digit_ctrl != 4'hF))
        else stop_with_failure("Display is dark while a value should be shown");

    done_check: assert property (@(posedge clk) disable iff (rst || !check_en)
        exe_done == exp_done)
        else value_mismatch("exe_done", $sampled(exe_done), $sampled(exp_done));

    stage_check: assert property (@(posedge clk) disable iff (rst || !check_en)
        display_stage == exp_stage)
        else value_mismatch("display_stage", $sampled(display_stage), $sampled(exp_stage));

    function automatic int rand_operand();
        return $random(seed) % 1000;
    endfunction

    function automatic int entry_value();
        int mag;
        mag = m_dig[0] + 10 * m_dig[1] + 100 * m_dig[2];
        return m_sign ? -mag : mag;
    endfunction

    task automatic compute_result();
        int r;
        int mag;
        res_valid = 1'b1;
        r = 0;
        if (m_sw[0]) begin
            r = m_a + m_b;
        end else if (m_sw[1]) begin
            r = m_a - m_b;
        end else if (m_sw[2]) begin
            r = m_a * m_b;
        end else if (m_sw[3] && m_b != 0) begin
            r = m_a / m_b;
        end else begin
            res_valid = 1'b0;
        end
        if (r > 32767 || r < -32768) begin
            res_valid = 1'b0;
        end
        res_neg  = r < 0;
        mag      = res_neg ? -r : r;
        res_page = res_valid && (mag > 999);
        for (int i = 0; i < 5; i++) begin
            res_dig[i] = mag % 10;
            mag = mag / 10;
        end
    endtask

    // Takes effect at the next edge, with the model state at this point
    task automatic refresh_expect();
        if (m_mode == M_BUSY) begin
            check_en <= 1'b0;
        end else if (m_mode == M_ENTRY) begin
            exp_seg[0] <= DIGIT_SEGS[m_dig[0]];
            exp_seg[1] <= DIGIT_SEGS[m_dig[1]];
            exp_seg[2] <= DIGIT_SEGS[m_dig[2]];
            exp_seg[3] <= m_sign ? MINUS_SEG : 8'h00;
            exp_blank  <= 1'b0;
            exp_done   <= 1'b0;
            exp_stage  <= 3'd0;
            check_en   <= 1'b1;
        end else begin
            if (res_page) begin
                exp_seg[0] <= DIGIT_SEGS[res_dig[3]];
                exp_seg[1] <= DIGIT_SEGS[res_dig[4]];
                exp_seg[2] <= 8'h00;
                exp_seg[3] <= 8'h00;
            end else begin
                exp_seg[0] <= DIGIT_SEGS[res_dig[0]];
                exp_seg[1] <= DIGIT_SEGS[res_dig[1]];
                exp_seg[2] <= DIGIT_SEGS[res_dig[2]];
                exp_seg[3] <= res_neg ? MINUS_SEG : 8'h00;
            end
            exp_blank <= !res_valid;
            exp_done  <= 1'b1;
            exp_stage <= {2'b00, res_page};
            check_en  <= 1'b1;
        end
    endtask

    task automatic apply_button(input int b);
        if (m_mode == M_ENTRY) begin
            case (b)
                `BTN_UP: begin
                    if (m_cursor == 3) begin
                        m_sign = !m_sign;
                    end else begin
                        m_dig[m_cursor] = (m_dig[m_cursor] + 1) % 10;
                    end
                end
                `BTN_DOWN: begin
                    if (m_cursor == 3) begin
                        m_sign = !m_sign;
                    end else begin
                        m_dig[m_cursor] = (m_dig[m_cursor] + 9) % 10;
                    end
                end
                `BTN_LEFT: begin
                    if (m_cursor < 3) m_cursor++;
                end
                `BTN_RIGHT: begin
                    if (m_cursor > 0) m_cursor--;
                end
                default: begin
                    if (m_in_b) begin
                        m_b = entry_value();
                    end else begin
                        m_a = entry_value();
                    end
                    m_dig    = '{0, 0, 0};
                    m_sign   = 1'b0;
                    m_cursor = 0;
                    if (m_in_b) begin
                        m_mode = M_BUSY;
                        compute_result();
                    end
                    m_in_b = !m_in_b;
                end
            endcase
        end else if (m_mode == M_DISPLAY && b == `BTN_MID) begin
            if (res_page) begin
                res_page = 1'b0;
            end else begin
                m_mode = M_ENTRY;
            end
        end
        refresh_expect();
    endtask

    // One-cycle pulse, checks resume once the display has caught up
    task automatic press(input int b);
        @(posedge clk);
        board_button <= `BUTTON_W'(1) << b;
        check_en     <= 1'b0;
        @(posedge clk);
        board_button <= '0;
        @(posedge clk);
        apply_button(b);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic set_digit(input int t);
        int ups;
        ups = (t - m_dig[m_cursor] + 10) % 10;
        if (ups <= 5) begin
            repeat (ups) press(`BTN_UP);
        end else begin
            repeat (10 - ups) press(`BTN_DOWN);
        end
    endtask

    task automatic enter_operand(input int v);
        int mag;
        mag = (v < 0) ? -v : v;
        while (m_cursor > 0) press(`BTN_RIGHT);
        set_digit(mag % 10);
        press(`BTN_LEFT);
        set_digit((mag / 10) % 10);
        press(`BTN_LEFT);
        set_digit(mag / 100);
        if (m_sign != (v < 0)) begin
            press(`BTN_LEFT);
            press(`BTN_UP);
        end
        press(`BTN_MID);
    endtask

    task automatic run_calc(input int a, input int b, input logic [`SWITCH_W-1:0] sw);
        @(posedge clk);
        board_switches <= sw;
        m_sw = sw[3:0];
        enter_operand(a);
        enter_operand(b);
        @(negedge clk);
        while (!exe_done) @(negedge clk);
        @(posedge clk);
        m_mode = M_DISPLAY;
        refresh_expect();
        idle(8);
        if (res_page) begin
            press(`BTN_MID);
            idle(8);
        end
        press(`BTN_MID);
        idle(4);
    endtask

    task automatic edit_digits();
        press(`BTN_DOWN);
        press(`BTN_UP);
        press(`BTN_RIGHT);
        // Fifth left hits the sign slot end stop
        repeat (5) press(`BTN_LEFT);
        press(`BTN_UP);
        press(`BTN_RIGHT);
        repeat (3) press(`BTN_DOWN);
        press(`BTN_RIGHT);
        repeat (12) press(`BTN_UP);
        repeat (4) press(`BTN_RIGHT);
        press(`BTN_DOWN);
        idle(6);
    endtask

    initial begin
        repeat (N_TESTS * TEST_CYCLES) @(posedge clk);
        stop_with_failure("Watchdog expired before all tests finished");
    end

    initial begin
        int a;
        int b;
        logic [`SWITCH_W-1:0] sw;
        seed           = 32'hc277;
        rst            = 1'b1;
        board_button   = '0;
        board_switches = '0;
        check_en       = 1'b0;
        exp_seg        = '{8'h00, 8'h00, 8'h00, 8'h00};
        exp_blank      = 1'b0;
        exp_done       = 1'b0;
        exp_stage      = 3'd0;
        m_dig          = '{0, 0, 0};
        m_sign         = 1'b0;
        m_cursor       = 0;
        m_mode         = M_ENTRY;
        m_in_b         = 1'b0;
        m_a            = 0;
        m_b            = 0;
        m_sw           = 4'd0;
        res_dig        = '{0, 0, 0, 0, 0};
        res_neg        = 1'b0;
        res_valid      = 1'b0;
        res_page       = 1'b0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        refresh_expect();
        idle(6);
        edit_digits();

        // Add and subtract, unused high switches random
        repeat (4) begin
            a  = rand_operand();
            b  = rand_operand();
            sw = `SWITCH_W'($random(seed)) & 15'h7FF0;
            sw = sw | (($random(seed) & 1) ? 15'h1 : 15'h2);
            run_calc(a, b, sw);
        end

        // Products between 1024 and 32761 need two pages
        repeat (2) begin
            a = 32 + ($unsigned($random(seed)) % 150);
            b = 32 + ($unsigned($random(seed)) % 150);
            if ($random(seed) & 1) a = -a;
            run_calc(a, b, 15'h4);
        end

        a = rand_operand();
        run_calc(a, 0, 15'h8);
        run_calc(999, -999, 15'h4);
        a  = rand_operand();
        b  = rand_operand();
        sw = (`SWITCH_W'($random(seed)) & 15'h7FF0) | 15'h10;
        run_calc(a, b, sw);

        a = rand_operand();
        b = rand_operand();
        run_calc(a, b, 15'hF);
        a = rand_operand();
        b = rand_operand();
        run_calc(a, b, 15'hA);
        run_calc(-997, 10, 15'hC);
        run_calc(-997, 10, 15'h7FF8);
        run_calc(500, -3, 15'h18);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+rtl
rtl/calc_ctrl_pkg.sv
rtl/calc_num_pkg.sv
rtl/calc_flow_if.sv
rtl/calc_control.sv
rtl/operand_entry.sv
rtl/result_unit.sv
rtl/display_scan.sv
rtl/calc_top.sv
testbench/calc_asserts.sv
testbench/calc_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module calc_tb -Mdir obj_dir
	./obj_dir/Vcalc_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
